// File: hdl/dmem_pkg.sv
package dmem_pkg;

    // one data word, used on both the CPU side and the memory side
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // access size code
    typedef logic [1:0]  size_t;

    // byte position inside an aligned word
    typedef logic [1:0]  offset_t;

    localparam size_t SIZE_B = 2'd0;   // byte
    localparam size_t SIZE_H = 2'd1;   // halfword
    localparam size_t SIZE_W = 2'd2;   // word

endpackage

// File: hdl/dmem_if.sv
`timescale 1ns/1ps

interface cpu_req_if;
    import dmem_pkg::*;

    logic    valid;
    logic    wen;
    size_t   size;
    addr_t   addr;
    word_t   wdata;
    offset_t offset;         // addr[1:0]
    addr_t   aligned_addr;   // addr with low bits cleared
    logic    two_words;      // access spans two aligned words
    logic    needs_read;     // memory must be read first
    logic    ready;

    modport source (
        output valid, wen, size, addr, wdata, offset, aligned_addr, two_words, needs_read,
        input  ready
    );

    modport sink (
        input  valid, wen, size, addr, wdata, offset, aligned_addr, two_words, needs_read,
        output ready
    );
endinterface

interface word_mem_if;
    import dmem_pkg::*;

    logic  valid;
    logic  wen;
    addr_t addr;         // word address, not byte address
    word_t wdata;
    logic  ready;
    logic  resp_valid;   // one cycle pulse per accepted request
    word_t rdata;

    modport master (
        output valid, wen, addr, wdata,
        input  ready, resp_valid, rdata
    );

    modport slave (
        input  valid, wen, addr, wdata,
        output ready, resp_valid, rdata
    );
endinterface

// File: hdl/req_capture.sv
`timescale 1ns/1ps

module req_capture (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    output logic            req_ready,
    input  logic            req_wen,
    input  dmem_pkg::size_t req_size,
    input  dmem_pkg::addr_t req_addr,
    input  dmem_pkg::word_t req_wdata,
    input  logic            done,
    cpu_req_if.source       cpu
);
    import dmem_pkg::*;

    logic  full;      // a request is held until done
    logic  pending;   // not yet taken by the controller
    logic  take;
    logic  wen_q;
    size_t size_q;
    addr_t addr_q;
    word_t wdata_q;

    assign req_ready = !full;
    assign take      = req_valid && !full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            pending <= 1'b0;
        end else if (take) begin
            full    <= 1'b1;
            pending <= 1'b1;
        end else begin
            if (cpu.valid && cpu.ready) begin
                pending <= 1'b0;
            end
            if (done) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wen_q   <= req_wen;
            size_q  <= req_size;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    assign cpu.valid        = pending;
    assign cpu.wen          = wen_q;
    assign cpu.size         = size_q;
    assign cpu.addr         = addr_q;
    assign cpu.wdata        = wdata_q;
    assign cpu.offset       = addr_q[1:0];
    assign cpu.aligned_addr = {addr_q[31:2], 2'b00};

    // misaligned word, or halfword starting in the top byte
    assign cpu.two_words  = (size_q == SIZE_W && addr_q[1:0] != 2'd0) ||
                            (size_q == SIZE_H && addr_q[1:0] == 2'd3);

    // only an aligned word store can skip the read
    assign cpu.needs_read = !wen_q || size_q != SIZE_W || addr_q[1:0] != 2'd0;

endmodule

// File: hdl/lane_merge.sv
`timescale 1ns/1ps

module lane_merge (
    input  dmem_pkg::offset_t offset,
    input  dmem_pkg::size_t   size,
    input  dmem_pkg::word_t   wdata,
    input  dmem_pkg::word_t   saved_word1,
    input  dmem_pkg::word_t   saved_word2,
    output dmem_pkg::word_t   load_word,
    output dmem_pkg::word_t   store_word1,
    output dmem_pkg::word_t   store_word2
);
    import dmem_pkg::*;

    logic [63:0] pair;         // saved words, lower address in low half
    logic [63:0] pair_shift;
    logic [4:0]  bit_shift;    // 8 * offset
    logic [3:0]  size_mask;    // bytes covered at offset 0
    logic [7:0]  lane_mask;    // bytes covered across the pair
    logic [63:0] data_shift;   // wdata moved up to the first byte
    logic [63:0] merged;

    assign pair      = {saved_word2, saved_word1};
    assign bit_shift = {offset, 3'b000};

    // load result is the four bytes starting at the offset
    assign pair_shift = pair >> bit_shift;
    assign load_word  = pair_shift[31:0];

    always_comb begin
        case (size)
            SIZE_B:  size_mask = 4'b0001;
            SIZE_H:  size_mask = 4'b0011;
            SIZE_W:  size_mask = 4'b1111;
            default: size_mask = 4'b1111;   // unused code, treat as word
        endcase
    end

    assign lane_mask  = {4'b0000, size_mask} << offset;
    assign data_shift = {32'd0, wdata} << bit_shift;

    // per byte pick new data or keep what memory held
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (lane_mask[i]) begin
                merged[8*i +: 8] = data_shift[8*i +: 8];
            end else begin
                merged[8*i +: 8] = pair[8*i +: 8];
            end
        end
    end

    assign store_word1 = merged[31:0];
    assign store_word2 = merged[63:32];   // only written when two_words

endmodule

// File: hdl/access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    cpu_req_if.sink         cpu,
    word_mem_if.master      mem,
    input  dmem_pkg::word_t load_word,
    input  dmem_pkg::word_t store_word1,
    input  dmem_pkg::word_t store_word2,
    output dmem_pkg::word_t saved_word1,
    output dmem_pkg::word_t saved_word2,
    output logic            done,
    output logic            resp_valid,
    output dmem_pkg::word_t resp_rdata
);
    import dmem_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        CHECK,
        READ,
        READ_WAIT,
        READ2,
        READ2_WAIT,
        MERGE,
        PUSH,
        WRITE,
        WRITE_WAIT,
        WRITE2,
        WRITE2_WAIT
    } state_t;

    state_t state;
    word_t  load_q;       // latched load result
    word_t  store_q1;
    word_t  store_q2;
    addr_t  second_addr;  // byte address of the upper word
    logic   second;       // current access targets the upper word
    logic   last_write;

    assign second_addr = cpu.aligned_addr + 32'd4;
    assign second      = (state == READ2) || (state == WRITE2);

    assign cpu.ready = (state == IDLE);

    assign mem.valid = (state == READ) || (state == READ2) ||
                       (state == WRITE) || (state == WRITE2);
    assign mem.wen   = (state == WRITE) || (state == WRITE2);
    assign mem.addr  = second ? {2'b00, second_addr[31:2]} : {2'b00, cpu.addr[31:2]};
    assign mem.wdata = (state == WRITE2) ? store_q2 : store_q1;

    // store ends with the response of its final write
    assign last_write = mem.resp_valid &&
                        ((state == WRITE_WAIT && !cpu.two_words) || state == WRITE2_WAIT);

    assign resp_valid = (state == PUSH) || last_write;
    assign done       = resp_valid;
    assign resp_rdata = load_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu.valid) begin
                        state <= cpu.wen ? CHECK : READ;
                    end
                end
                CHECK:       state <= cpu.needs_read ? READ : WRITE;
                READ: begin
                    if (mem.ready) state <= READ_WAIT;
                end
                READ_WAIT: begin
                    if (mem.resp_valid) state <= cpu.two_words ? READ2 : MERGE;
                end
                READ2: begin
                    if (mem.ready) state <= READ2_WAIT;
                end
                READ2_WAIT: begin
                    if (mem.resp_valid) state <= MERGE;
                end
                MERGE:       state <= cpu.wen ? WRITE : PUSH;
                PUSH:        state <= IDLE;
                WRITE: begin
                    if (mem.ready) state <= WRITE_WAIT;
                end
                WRITE_WAIT: begin
                    if (mem.resp_valid) state <= cpu.two_words ? WRITE2 : IDLE;
                end
                WRITE2: begin
                    if (mem.ready) state <= WRITE2_WAIT;
                end
                WRITE2_WAIT: begin
                    if (mem.resp_valid) state <= IDLE;
                end
                default:     state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == READ_WAIT && mem.resp_valid) begin
            saved_word1 <= mem.rdata;
        end
        if (state == READ2_WAIT && mem.resp_valid) begin
            saved_word2 <= mem.rdata;
        end
        if (state == CHECK) begin
            store_q1 <= cpu.wdata;   // aligned word goes out unchanged
        end
        if (state == MERGE) begin
            load_q   <= load_word;
            store_q1 <= store_word1;
            store_q2 <= store_word2;
        end
    end

endmodule

// File: hdl/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter int RAM_WORDS  = 256,
    parameter int RESP_DELAY = 1
) (
    input  logic      clk,
    input  logic      rst_n,
    word_mem_if.slave mem
);
    import dmem_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    word_t            ram [RAM_WORDS];
    word_t            rdata_q;
    logic [IDX_W-1:0] idx;
    logic [2:0]       cnt;      // cycles left until the response
    logic             accept;

    assign idx    = IDX_W'(mem.addr % RAM_WORDS);   // wraps on the array size
    assign accept = mem.valid && mem.ready;

    assign mem.ready      = (cnt == 3'd0);
    assign mem.resp_valid = (cnt == 3'd1);
    assign mem.rdata      = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= 3'd0;
        end else if (accept) begin
            cnt <= 3'(RESP_DELAY);
        end else if (cnt != 3'd0) begin
            cnt <= cnt - 3'd1;
        end
    end

    // read data is the contents before a write at the same address
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= ram[idx];
            if (mem.wen) begin
                ram[idx] <= mem.wdata;
            end
        end
    end

endmodule

// File: hdl/dmem_unit.sv
`timescale 1ns/1ps

module dmem_unit #(
    parameter int RAM_WORDS  = 256,
    parameter int RESP_DELAY = 1     // 1 to 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    output logic            req_ready,
    input  logic            req_wen,
    input  dmem_pkg::size_t req_size,
    input  dmem_pkg::addr_t req_addr,
    input  dmem_pkg::word_t req_wdata,
    output logic            resp_valid,
    output dmem_pkg::word_t resp_rdata
);
    import dmem_pkg::*;

    cpu_req_if  cpu_bus ();
    word_mem_if mem_bus ();

    logic  done;
    word_t load_word;
    word_t store_word1;
    word_t store_word2;
    word_t saved_word1;
    word_t saved_word2;

    req_capture u_req_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .done      (done),
        .cpu       (cpu_bus)
    );

    access_ctrl u_access_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu         (cpu_bus),
        .mem         (mem_bus),
        .load_word   (load_word),
        .store_word1 (store_word1),
        .store_word2 (store_word2),
        .saved_word1 (saved_word1),
        .saved_word2 (saved_word2),
        .done        (done),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata)
    );

    lane_merge u_lane_merge (
        .offset      (cpu_bus.offset),
        .size        (cpu_bus.size),
        .wdata       (cpu_bus.wdata),
        .saved_word1 (saved_word1),
        .saved_word2 (saved_word2),
        .load_word   (load_word),
        .store_word1 (store_word1),
        .store_word2 (store_word2)
    );

    word_ram #(
        .RAM_WORDS  (RAM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) u_word_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus)
    );

endmodule

// File: test/tb_vectors.svh
// one table row
typedef struct packed {
    logic  wen;
    size_t size;
    addr_t addr;
    word_t wdata;
    word_t exp;     // unused for stores
} vec_t;

vec_t  vecs[$];
string vec_names[$];

task automatic add_vec(input string name, input logic wen, input size_t size,
                       input addr_t addr, input word_t wdata, input word_t exp);
    vec_t v;
    v.wen   = wen;
    v.size  = size;
    v.addr  = addr;
    v.wdata = wdata;
    v.exp   = exp;
    vecs.push_back(v);
    vec_names.push_back(name);
endtask

// memory bytes 0 to 7 become be be fe ca ef be ad de
task automatic build_table();
    add_vec("st_w_000", 1'b1, SIZE_W, 32'h000, 32'hcafe_bebe, 32'h0);
    add_vec("st_w_004", 1'b1, SIZE_W, 32'h004, 32'hdead_beef, 32'h0);
    add_vec("ld_w_000", 1'b0, SIZE_W, 32'h000, 32'h0, 32'hcafe_bebe);
    add_vec("ld_w_001", 1'b0, SIZE_W, 32'h001, 32'h0, 32'hefca_febe);   // two reads
    add_vec("ld_w_002", 1'b0, SIZE_W, 32'h002, 32'h0, 32'hbeef_cafe);
    add_vec("ld_w_003", 1'b0, SIZE_W, 32'h003, 32'h0, 32'hadbe_efca);
    add_vec("st_w_010", 1'b1, SIZE_W, 32'h010, 32'h3322_1100, 32'h0);
    add_vec("st_w_014", 1'b1, SIZE_W, 32'h014, 32'h7766_5544, 32'h0);
    add_vec("st_w_018", 1'b1, SIZE_W, 32'h018, 32'hbbaa_9988, 32'h0);
    add_vec("st_b_010", 1'b1, SIZE_B, 32'h010, 32'hffff_ffa0, 32'h0);   // upper data ignored
    add_vec("st_b_013", 1'b1, SIZE_B, 32'h013, 32'hffff_ffa3, 32'h0);
    add_vec("st_b_011", 1'b1, SIZE_B, 32'h011, 32'h5a5a_5aa1, 32'h0);
    add_vec("ld_w_010", 1'b0, SIZE_W, 32'h010, 32'h0, 32'ha322_a1a0);
    add_vec("st_b_012", 1'b1, SIZE_B, 32'h012, 32'h0000_00a2, 32'h0);
    add_vec("ld_w_010", 1'b0, SIZE_W, 32'h010, 32'h0, 32'ha3a2_a1a0);
    add_vec("st_h_014", 1'b1, SIZE_H, 32'h014, 32'hffff_b1b0, 32'h0);
    add_vec("st_h_016", 1'b1, SIZE_H, 32'h016, 32'h0000_c3c2, 32'h0);
    add_vec("st_h_015", 1'b1, SIZE_H, 32'h015, 32'heeee_d5d4, 32'h0);
    add_vec("ld_w_014", 1'b0, SIZE_W, 32'h014, 32'h0, 32'hc3d5_d4b0);
    add_vec("st_h_017", 1'b1, SIZE_H, 32'h017, 32'h1234_e7e6, 32'h0);   // crosses a word
    add_vec("ld_w_014", 1'b0, SIZE_W, 32'h014, 32'h0, 32'he6d5_d4b0);
    add_vec("ld_w_018", 1'b0, SIZE_W, 32'h018, 32'h0, 32'hbbaa_99e7);
    add_vec("ld_h_017", 1'b0, SIZE_H, 32'h017, 32'h0, 32'haa99_e7e6);
    add_vec("ld_b_012", 1'b0, SIZE_B, 32'h012, 32'h0, 32'hd4b0_a3a2);
    add_vec("ld_h_001", 1'b0, SIZE_H, 32'h001, 32'h0, 32'hefca_febe);
    add_vec("st_w_020", 1'b1, SIZE_W, 32'h020, 32'h0302_0100, 32'h0);
    add_vec("st_w_024", 1'b1, SIZE_W, 32'h024, 32'h0706_0504, 32'h0);
    add_vec("st_w_028", 1'b1, SIZE_W, 32'h028, 32'h0b0a_0908, 32'h0);
    add_vec("st_w_02c", 1'b1, SIZE_W, 32'h02c, 32'h0f0e_0d0c, 32'h0);
    add_vec("st_w_021", 1'b1, SIZE_W, 32'h021, 32'h4433_2211, 32'h0);
    add_vec("ld_w_020", 1'b0, SIZE_W, 32'h020, 32'h0, 32'h3322_1100);
    add_vec("ld_w_024", 1'b0, SIZE_W, 32'h024, 32'h0, 32'h0706_0544);
    add_vec("st_w_026", 1'b1, SIZE_W, 32'h026, 32'h8877_6655, 32'h0);
    add_vec("ld_w_024", 1'b0, SIZE_W, 32'h024, 32'h0, 32'h6655_0544);
    add_vec("st_w_02b", 1'b1, SIZE_W, 32'h02b, 32'hccbb_aa99, 32'h0);
    add_vec("ld_w_028", 1'b0, SIZE_W, 32'h028, 32'h0, 32'h990a_8877);
    add_vec("ld_w_02c", 1'b0, SIZE_W, 32'h02c, 32'h0, 32'h0fcc_bbaa);
    add_vec("ld_w_02b", 1'b0, SIZE_W, 32'h02b, 32'h0, 32'hccbb_aa99);
endtask

// File: test/tb_dmem_unit.sv
`timescale 1ns/1ps

module tb_dmem_unit;
    import dmem_pkg::*;

    localparam int    RAND_COUNT = 60;
    localparam int    FILL_WORDS = 16;
    localparam addr_t RAND_BASE  = 32'h100;
    localparam int    WAIT_LIMIT = 40;   // cycles per handshake step

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_ready;
    logic  req_wen;
    size_t req_size;
    addr_t req_addr;
    word_t req_wdata;
    logic  resp_valid;
    word_t resp_rdata;

    logic [7:0] model [1024];   // byte image that wraps like the 256 RAM words
    int         errors;
    int         requests;
    int         resp_count;
    logic       table_built;

    `include "tb_vectors.svh"

    dmem_unit #(
        .RAM_WORDS  (256),
        .RESP_DELAY (1)
    ) u_dmem_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_wen    (req_wen),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && resp_valid)
            resp_count++;
    end

    function automatic int size_bytes(input size_t size);
        case (size)
            SIZE_B:  return 1;
            SIZE_H:  return 2;
            default: return 4;
        endcase
    endfunction

    // bytes past the first word are fetched only for two-word accesses
    function automatic word_t load_mask(input size_t size, input addr_t addr);
        logic spans;
        spans = (size == SIZE_W && addr[1:0] != 2'd0) || (size == SIZE_H && addr[1:0] == 2'd3);
        if (spans)
            return 32'hffff_ffff;
        return 32'hffff_ffff >> (8 * addr[1:0]);
    endfunction

    function automatic word_t model_load(input addr_t addr);
        word_t v;
        for (int i = 0; i < 4; i++)
            v[8*i +: 8] = model[(addr + i) & 32'h3ff];   // little endian
        return v;
    endfunction

    task automatic model_store(input size_t size, input addr_t addr, input word_t wdata);
        for (int i = 0; i < size_bytes(size); i++)
            model[(addr + i) & 32'h3ff] = wdata[8*i +: 8];
    endtask

    task automatic run_access(input logic wen, input size_t size, input addr_t addr,
                              input word_t wdata, output word_t rdata);
        int waited;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_wen   = wen;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        requests++;
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            $display("request %0d at address %h was never accepted", requests, addr);
            errors++;
        end
        @(posedge clk);   // request taken here
        #2;
        req_valid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!resp_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!resp_valid) begin
            $display("no response to request %0d at address %h", requests, addr);
            errors++;
        end
        rdata = resp_rdata;
    endtask

    task automatic check_load(input string name, input int idx, input size_t size,
                              input addr_t addr, input word_t exp, input word_t act);
        if (((exp ^ act) & load_mask(size, addr)) != 32'd0) begin
            $display("FAIL %s_%0d: expected %h, actual %h", name, idx, exp, act);
            errors++;
        end
    endtask

    initial begin : watchdog
        wait (table_built);
        repeat ((vecs.size() + FILL_WORDS + RAND_COUNT + 2) * 40) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        word_t rdata;
        logic  wen;
        size_t size;
        addr_t addr;
        word_t wdata;
        int    seed_val;
        seed_val    = $urandom(32'hc7ae_0997);
        errors      = 0;
        requests    = 0;
        resp_count  = 0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_wen     = 1'b0;
        req_size    = SIZE_W;
        req_addr    = '0;
        req_wdata   = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (!req_ready || resp_valid) begin
            $display("after reset req_ready is low or resp_valid is high");
            errors++;
        end
        for (int i = 0; i < vecs.size(); i++) begin
            run_access(vecs[i].wen, vecs[i].size, vecs[i].addr, vecs[i].wdata, rdata);
            if (vecs[i].wen)
                model_store(vecs[i].size, vecs[i].addr, vecs[i].wdata);
            else
                check_load(vec_names[i], i, vecs[i].size, vecs[i].addr, vecs[i].exp, rdata);
        end
        for (int w = 0; w < FILL_WORDS; w++) begin   // defined contents for random loads
            wdata = $urandom;
            run_access(1'b1, SIZE_W, RAND_BASE + 4 * w, wdata, rdata);
            model_store(SIZE_W, RAND_BASE + 4 * w, wdata);
        end
        for (int n = 0; n < RAND_COUNT; n++) begin
            wen   = $urandom_range(0, 1);
            size  = size_t'($urandom_range(0, 2));
            addr  = RAND_BASE + $urandom_range(0, 4 * FILL_WORDS - 5);
            wdata = $urandom;
            run_access(wen, size, addr, wdata, rdata);
            if (wen)
                model_store(size, addr, wdata);
            else
                check_load("rand", n, size, addr, model_load(addr), rdata);
        end
        @(posedge clk);
        if (resp_count != requests) begin
            $display("saw %0d responses for %0d requests", resp_count, requests);
            errors++;
        end
        $display("requests %0d, errors %0d", requests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
hdl/dmem_pkg.sv
hdl/dmem_if.sv
hdl/req_capture.sv
hdl/lane_merge.sv
hdl/access_ctrl.sv
hdl/word_ram.sv
hdl/dmem_unit.sv
test/tb_dmem_unit.sv
